// ==== logic/clkgen_pkg.sv ====
// shared constants, register map and reconfiguration word types for the clock generator
`default_nettype none

package clkgen_pkg;

  // ####################
  // sizes
  // ####################
  localparam int NUM_CHANNELS = 4;
  localparam int LOCK_CYCLES  = 16;   // edges from lock loss to lock
  localparam int LOCK_CNT_W   = $clog2(LOCK_CYCLES + 1);
  localparam int ADDR_W       = 7;
  localparam int DATA_W       = 16;
  localparam int CNT_W        = 8;    // high, low and phase counts

  // ####################
  // register map
  // ####################
  localparam int ADDR_DIV_BASE   = 0; // divide regs at 0..3
  localparam int ADDR_PHASE_BASE = 4; // phase regs at 4..7
  localparam int NUM_REGS        = ADDR_PHASE_BASE + NUM_CHANNELS;
  localparam int REG_IDX_W       = $clog2(NUM_REGS);

  // divide view of a register word
  typedef struct packed {
    logic [CNT_W-1:0] high_m1;        // high count minus one
    logic [CNT_W-1:0] low_m1;         // low count minus one
  } div_cfg_t;

  // phase view of a register word
  typedef struct packed {
    logic                      enable;
    logic [DATA_W-CNT_W-2:0]   rsvd;  // kept as written
    logic [CNT_W-1:0]          phase; // offset in input cycles
  } phase_cfg_t;

  // one stored word, decoded by its address
  typedef union packed {
    div_cfg_t   div;
    phase_cfg_t ph;
  } drp_word_u;

  typedef logic [NUM_CHANNELS-1:0] chan_vec_t;

  // power-up contents
  localparam div_cfg_t   DIV_RESET   = '0;  // divide by two
  localparam phase_cfg_t PHASE_RESET = '{enable: 1'b1, rsvd: '0, phase: '0};

endpackage

`default_nettype wire

// ==== logic/drp_if.sv ====
// dynamic reconfiguration port bundle between the top level and the controller
`timescale 1ns/1ps
`default_nettype none

interface drp_if;
  import clkgen_pkg::*;

  logic              den;      // one access per cycle high
  logic              dwe;      // write when set
  logic [ADDR_W-1:0] daddr;
  logic [DATA_W-1:0] di;
  logic [DATA_W-1:0] do_data;  // valid with drdy on reads
  logic              drdy;     // one cycle after den

  // top-level side
  modport host (
    output den, dwe, daddr, di,
    input  do_data, drdy
  );

  // register file side
  modport controller (
    input  den, dwe, daddr, di,
    output do_data, drdy
  );

endinterface

`default_nettype wire

// ==== logic/chan_cfg_if.sv ====
// configuration of one output channel from the controller to its divider
`timescale 1ns/1ps
`default_nettype none

interface chan_cfg_if;
  import clkgen_pkg::*;

  logic [CNT_W-1:0] high_m1;  // high count minus one
  logic [CNT_W-1:0] low_m1;   // low count minus one
  logic [CNT_W-1:0] phase;    // cycles to wait after lock
  logic             enable;

  modport source (
    output high_m1, low_m1, phase, enable
  );

  modport sink (
    input high_m1, low_m1, phase, enable
  );

endinterface

`default_nettype wire

// ==== logic/clkgen_ctrl.sv ====
// channel register file behind the reconfiguration port, flags every mapped write
`timescale 1ns/1ps
`default_nettype none

module clkgen_ctrl (
  input  logic       CLKIN1,
  input  logic       reset,
  drp_if.controller  drp,
  chan_cfg_if.source cfg [clkgen_pkg::NUM_CHANNELS],
  output logic       reconfig
);
  import clkgen_pkg::*;

  drp_word_u            regs [NUM_REGS];
  logic                 mapped;
  logic [REG_IDX_W-1:0] idx;
  logic [DATA_W-1:0]    rdata;

  // ####################
  // address decode
  // ####################
  assign mapped = (drp.daddr < ADDR_W'(NUM_REGS));
  assign idx    = drp.daddr[REG_IDX_W-1:0];

  // unmapped reads return zero
  always_comb
  begin
    rdata = '0;
    if (mapped)
      rdata = regs[idx];
  end

  // lock restarts on any mapped write
  assign reconfig = drp.den & drp.dwe & mapped;

  // ####################
  // register file
  // ####################
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      for (int c = 0; c < NUM_CHANNELS; c++)
      begin
        regs[ADDR_DIV_BASE + c].div  <= DIV_RESET;
        regs[ADDR_PHASE_BASE + c].ph <= PHASE_RESET;
      end
    end
    else if (reconfig)
    begin
      regs[idx] <= drp.di;  // raw word, view picked on use
    end
  end

  // handshake
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
      drp.drdy <= 1'b0;
    else
      drp.drdy <= drp.den;
  end

  // read data holds between accesses
  always_ff @(posedge CLKIN1)
  begin
    if (drp.den)
      drp.do_data <= rdata;
  end

  // ####################
  // channel views
  // ####################
  for (genvar c = 0; c < NUM_CHANNELS; c++)
  begin : g_cfg
    assign cfg[c].high_m1 = regs[ADDR_DIV_BASE + c].div.high_m1;
    assign cfg[c].low_m1  = regs[ADDR_DIV_BASE + c].div.low_m1;
    assign cfg[c].phase   = regs[ADDR_PHASE_BASE + c].ph.phase;
    assign cfg[c].enable  = regs[ADDR_PHASE_BASE + c].ph.enable;
  end

  // back-to-back drdy only after back-to-back den
  a_drdy_pairs: assert property (@(posedge CLKIN1) disable iff (reset)
    drp.drdy && $past(drp.drdy) |-> $past(drp.den) && $past(drp.den, 2));

  // no accesses while the block is held in reset
  a_no_den_in_reset: assert property (@(posedge CLKIN1)
    reset |-> !drp.den);

endmodule

`default_nettype wire

// ==== logic/lock_monitor.sv ====
// lock counter that drops lock on reconfiguration and regains it after a fixed count
`timescale 1ns/1ps
`default_nettype none

module lock_monitor (
  input  logic CLKIN1,
  input  logic reset,
  input  logic reconfig,
  output logic locked
);
  import clkgen_pkg::*;

  logic [LOCK_CNT_W-1:0] lock_cnt;

  // ####################
  // down-counter
  // ####################
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      lock_cnt <= LOCK_CNT_W'(LOCK_CYCLES);
    end
    else if (reconfig)
    begin
      lock_cnt <= LOCK_CNT_W'(LOCK_CYCLES);  // restart, even mid-count
    end
    else if (lock_cnt != '0)
    begin
      lock_cnt <= lock_cnt - 1'b1;
    end
  end

  // holds at zero until the next reconfig
  assign locked = (lock_cnt == '0);

  // lock is only lost through a mapped write
  a_lock_drop: assert property (@(posedge CLKIN1) disable iff (reset)
    $fell(locked) |-> $past(reconfig));

endmodule

`default_nettype wire

// ==== logic/clk_divider.sv ====
// one output channel generating a phase delay and then a high/low level pattern
`timescale 1ns/1ps
`default_nettype none

module clk_divider (
  input  logic       CLKIN1,
  input  logic       reset,
  input  logic       locked,
  chan_cfg_if.sink   cfg,
  output logic       level
);
  import clkgen_pkg::*;

  logic [CNT_W-1:0] phase_cnt;  // edges waited since lock
  logic [CNT_W-1:0] seg_cnt;    // position in current high or low run
  logic [CNT_W-1:0] seg_end;
  logic             running;    // offset done
  logic             level_q;

  // last count of the current run
  assign seg_end = level_q ? cfg.high_m1 : cfg.low_m1;

  // ####################
  // phase and run counters
  // ####################
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      phase_cnt <= '0;
      seg_cnt   <= '0;
      running   <= 1'b0;
      level_q   <= 1'b0;
    end
    else if (!locked || !cfg.enable)
    begin
      phase_cnt <= '0;
      seg_cnt   <= '0;
      running   <= 1'b0;
      level_q   <= 1'b0;
    end
    else if (!running)
    begin
      if (phase_cnt == cfg.phase)
      begin
        running <= 1'b1;  // first high run starts here
        level_q <= 1'b1;
        seg_cnt <= '0;
      end
      else
      begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
    else if (seg_cnt == seg_end)
    begin
      level_q <= !level_q;
      seg_cnt <= '0;
    end
    else
    begin
      seg_cnt <= seg_cnt + 1'b1;
    end
  end

  // lock loss takes effect in the same cycle
  assign level = level_q & locked;

  // channel also stays low in the first cycle after lock returns
  a_low_unlocked: assert property (@(posedge CLKIN1) disable iff (reset)
    !locked |=> !level);

endmodule

`default_nettype wire

// ==== logic/clkgen_top.sv ====
// clock generator top level joining the controller, the lock counter and four channels
`timescale 1ns/1ps
`default_nettype none

module clkgen_top (
  input  logic                           CLKIN1,
  input  logic                           reset,
  input  logic                           DEN,
  input  logic                           DWE,
  input  logic [clkgen_pkg::ADDR_W-1:0]  DADDR,
  input  logic [clkgen_pkg::DATA_W-1:0]  DI,
  output logic [clkgen_pkg::DATA_W-1:0]  DO,
  output logic                           DRDY,
  output logic                           LOCKED,
  output clkgen_pkg::chan_vec_t          CLKOUT
);
  import clkgen_pkg::*;

  logic reconfig;
  logic locked;

  drp_if      drp_bus ();
  chan_cfg_if cfg_bus [NUM_CHANNELS] ();

  // ####################
  // reconfiguration port
  // ####################
  assign drp_bus.den   = DEN;
  assign drp_bus.dwe   = DWE;
  assign drp_bus.daddr = DADDR;
  assign drp_bus.di    = DI;
  assign DO            = drp_bus.do_data;
  assign DRDY          = drp_bus.drdy;
  assign LOCKED        = locked;

  clkgen_ctrl ctrl_i (
    .CLKIN1   (CLKIN1),
    .reset    (reset),
    .drp      (drp_bus),
    .cfg      (cfg_bus),
    .reconfig (reconfig)
  );

  lock_monitor lock_i (
    .CLKIN1   (CLKIN1),
    .reset    (reset),
    .reconfig (reconfig),
    .locked   (locked)
  );

  // ####################
  // output channels
  // ####################
  for (genvar c = 0; c < NUM_CHANNELS; c++)
  begin : g_chan
    clk_divider div_i (
      .CLKIN1 (CLKIN1),
      .reset  (reset),
      .locked (locked),
      .cfg    (cfg_bus[c]),
      .level  (CLKOUT[c])
    );
  end

endmodule

`default_nettype wire

// ==== test/clkgen_tb.sv ====
// testbench driving random reconfiguration traffic into the clock generator against a model
`timescale 1ns/1ps
`default_nettype none

module clkgen_tb;
  import clkgen_pkg::*;

  localparam int RESET_CYCLES     = 16;
  localparam int NUM_PHASES       = 40;
  localparam int CYCLES_PER_PHASE = 400;
  localparam int TIMEOUT_CYCLES   = NUM_PHASES * CYCLES_PER_PHASE + RESET_CYCLES + 500;

  logic              CLKIN1;
  logic              reset;
  logic              den;
  logic              dwe;
  logic [ADDR_W-1:0] daddr;
  logic [DATA_W-1:0] di;
  logic [DATA_W-1:0] do_data;
  logic              drdy;
  logic              locked;
  chan_vec_t         clkout;
  integer            seed = 32'he96e_b6cb;
  int                cycles = 0;

  // reference model
  drp_word_u m_regs [NUM_REGS];
  int        m_cnt;   // edges left until lock
  int        m_k;     // edges since lock rose
  logic      m_drdy;
  logic      m_rd;
  drp_word_u m_do;

  clkgen_top clkgen_top_i (
    .CLKIN1 (CLKIN1),
    .reset  (reset),
    .DEN    (den),
    .DWE    (dwe),
    .DADDR  (daddr),
    .DI     (di),
    .DO     (do_data),
    .DRDY   (drdy),
    .LOCKED (locked),
    .CLKOUT (clkout)
  );

  initial
  begin
    CLKIN1 = 1'b0;
    forever #50 CLKIN1 = ~CLKIN1;
  end

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, model expects %b", what, got, exp));
  endtask

  task automatic check_read(input drp_word_u got, input drp_word_u exp);
    if (got !== exp)
      report_mismatch($sformatf("read data %h, model expects %h", got, exp));
  endtask

  task automatic check_level(input chan_vec_t got, input chan_vec_t exp);
    if (got !== exp)
      report_mismatch($sformatf("channel levels %b, model expects %b", got, exp));
  endtask

  // ####################
  // model
  // ####################
  function automatic chan_vec_t predict_levels();
    chan_vec_t            v;
    logic [REG_IDX_W-1:0] d_idx;
    logic [REG_IDX_W-1:0] p_idx;
    int                   hi;
    int                   lo;
    int                   off;
    logic                 bit_c;
    v = '0;
    for (int c = NUM_CHANNELS - 1; c >= 0; c--)
    begin
      d_idx = REG_IDX_W'(ADDR_DIV_BASE + c);
      p_idx = REG_IDX_W'(ADDR_PHASE_BASE + c);
      hi    = int'(m_regs[d_idx].div.high_m1) + 1;
      lo    = int'(m_regs[d_idx].div.low_m1) + 1;
      off   = int'(m_regs[p_idx].ph.phase) + 1;  // first high edge after lock
      bit_c = (m_cnt == 0) && m_regs[p_idx].ph.enable && (m_k >= off)
              && (((m_k - off) % (hi + lo)) < hi);
      v     = {v[NUM_CHANNELS-2:0], bit_c};  // channel 3 ends up on top
    end
    return v;
  endfunction

  // one rising edge, using the inputs the DUT samples there
  task automatic step_model();
    logic                 was_locked;
    logic                 mapped;
    logic [REG_IDX_W-1:0] idx;
    was_locked = (m_cnt == 0);
    mapped     = (int'(daddr) < NUM_REGS);
    idx        = daddr[REG_IDX_W-1:0];
    m_drdy     = den;
    if (den)
    begin
      m_rd = !dwe;
      m_do = '0;  // unmapped reads as zero
      if (mapped)
        m_do = m_regs[idx];
    end
    if (den && dwe && mapped)
    begin
      m_regs[idx] = di;
      m_cnt       = LOCK_CYCLES;  // relock from the start
    end
    else if (m_cnt != 0)
      m_cnt--;
    if (m_cnt == 0)
      m_k = was_locked ? m_k + 1 : 0;
  endtask

  task automatic check_outputs();
    check_flag(locked, m_cnt == 0, "LOCKED");
    check_flag(drdy, m_drdy, "DRDY");
    if (m_drdy && m_rd)
      check_read(do_data, m_do);
    check_level(clkout, predict_levels());
  endtask

  // ####################
  // stimulus
  // ####################
  task automatic start_access(input logic we, input int addr, input logic [DATA_W-1:0] data);
    den   <= 1'b1;
    dwe   <= we;
    daddr <= ADDR_W'(addr);
    di    <= data;
  endtask

  // small counts keep several periods inside one test phase
  function automatic drp_word_u small_config(input int addr, input drp_word_u raw);
    drp_word_u w;
    w = raw;
    if (addr < ADDR_PHASE_BASE)
    begin
      w.div.high_m1 = CNT_W'(rand_below(4));
      w.div.low_m1  = CNT_W'(rand_below(4));
    end
    else
    begin
      w.ph.enable = (rand_below(4) != 0);  // mostly on
      w.ph.phase  = CNT_W'(rand_below(12));
    end
    return w;
  endfunction

  task automatic pick_access(input int kind, input int cyc);
    drp_word_u w;
    int        a;
    w   = DATA_W'(rand_below(65536));
    den <= 1'b0;
    dwe <= 1'b0;
    if (kind == 0 && cyc < 24)
      start_access(1'b0, rand_below(12), w);     // back-to-back reads
    else if (kind == 1 && cyc == 0)
    begin
      a = ADDR_DIV_BASE + rand_below(NUM_CHANNELS);
      start_access(1'b1, a, small_config(a, w));
    end
    else if (kind == 2 && cyc == 0)
    begin
      a = ADDR_PHASE_BASE + rand_below(NUM_CHANNELS);
      start_access(1'b1, a, small_config(a, w));
    end
    else if (kind == 3 && cyc == 0)
      start_access(1'b1, NUM_REGS + rand_below(128 - NUM_REGS), w);
    else if (kind == 4 && (cyc == 0 || cyc == 6 || cyc == 13))
    begin
      a = rand_below(NUM_REGS);                  // lands inside the lock count
      start_access(1'b1, a, small_config(a, w));
    end
    else if (rand_below(8) == 0)
      start_access(1'b0, rand_below(16), w);
  endtask

  initial
  begin
    reset  <= 1'b1;
    den    <= 1'b0;
    dwe    <= 1'b0;
    daddr  <= '0;
    di     <= '0;
    m_cnt  = LOCK_CYCLES;
    m_k    = 0;
    m_drdy = 1'b0;
    m_rd   = 1'b0;
    m_do   = '0;
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      m_regs[REG_IDX_W'(ADDR_DIV_BASE + c)].div  = '0;
      m_regs[REG_IDX_W'(ADDR_PHASE_BASE + c)].ph = '{enable: 1'b1, rsvd: '0, phase: '0};
    end
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(posedge CLKIN1);
      if (i == RESET_CYCLES - 1)
        reset <= 1'b0;
      @(negedge CLKIN1);
      check_outputs();
    end
    for (int p = 0; p < NUM_PHASES; p++)
    begin
      for (int c = 0; c < CYCLES_PER_PHASE; c++)
      begin
        @(posedge CLKIN1);
        step_model();
        pick_access(p % 5, c);
        @(negedge CLKIN1);
        check_outputs();  // outputs settled mid-cycle
      end
    end
    $display("All checks passed");
    $finish;
  end

  // run limit
  always @(posedge CLKIN1)
  begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/clkgen_pkg.sv
logic/drp_if.sv
logic/chan_cfg_if.sv
logic/clkgen_ctrl.sv
logic/lock_monitor.sv
logic/clk_divider.sv
logic/clkgen_top.sv
test/clkgen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module clkgen_tb -o clkgen_sim

status=0
./obj_dir/clkgen_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
